/* zicsr_cfg.svh */
// data width, hart id, writable mstatus bits and machine CSR addresses
`ifndef ZICSR_CFG_SVH
`define ZICSR_CFG_SVH

// one machine word
`define ZICSR_XLEN 32

// value returned by a read of mhartid
`define ZICSR_HARTID 32'h0000_0001

// only MPIE (bit 7) and MIE (bit 3) of mstatus can be written
`define ZICSR_MSTATUS_WMASK 32'h0000_0088

// machine mode CSR addresses
`define ZICSR_ADDR_MSTATUS  12'h300
`define ZICSR_ADDR_MTVEC    12'h305
`define ZICSR_ADDR_MSCRATCH 12'h340
`define ZICSR_ADDR_MEPC     12'h341
`define ZICSR_ADDR_MCAUSE   12'h342
`define ZICSR_ADDR_MHARTID  12'hF14

`endif

/* zicsr_pkg.sv */
// CSR operation enum, CSR instruction word union and trap cause enum
package zicsr_pkg;

  // encoded like funct3, so a legal funct3 casts straight to its operation
  typedef enum logic [2:0] {
    CSR_NONE = 3'b000,
    CSR_RW   = 3'b001,
    CSR_RS   = 3'b010,
    CSR_RC   = 3'b011,
    CSR_RWI  = 3'b101,
    CSR_RSI  = 3'b110,
    CSR_RCI  = 3'b111
  } csr_op_e;

  // the same 32-bit word read with a register source or with a 5-bit immediate
  // funct3[2] tells which view applies
  typedef union packed {
    struct packed {
      logic [11:0] csr;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } reg_fmt;
    struct packed {
      logic [11:0] csr;
      logic [4:0]  uimm;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } imm_fmt;
  } csr_inst_u;

  // mcause style codes
  // a bad CSR access gets its own code 15 so it stays apart from an illegal opcode,
  // and a clean retire reports the reserved code 14
  typedef enum logic [3:0] {
    TRAP_MISALIGNED_PC = 4'd0,
    TRAP_ILLEGAL_INST  = 4'd2,
    TRAP_NONE          = 4'd14,
    TRAP_CSR_ACCESS    = 4'd15
  } trap_cause_e;

endpackage

/* csr_decode.sv */
// CSR instruction decoder: SYSTEM opcode and funct3 check, field extraction per format
`timescale 1ns/1ps

module csr_decode (
  input  zicsr_pkg::csr_inst_u inst,
  output zicsr_pkg::csr_op_e   op,
  output logic [11:0]          csr_addr,
  output logic [4:0]           src_idx,
  output logic [4:0]           rd,
  output logic                 illegal
);

  import zicsr_pkg::*;

  localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

  logic       is_system;
  logic       funct3_ok;
  logic [2:0] funct3;
  logic       imm_form;

  assign funct3    = inst.reg_fmt.funct3;
  assign is_system = (inst.reg_fmt.opcode == OPCODE_SYSTEM);

  // funct3 of 000 is ECALL/EBREAK territory and 100 is reserved
  always_comb
  begin
    case (funct3)
      3'b001,
      3'b010,
      3'b011,
      3'b101,
      3'b110,
      3'b111:
      begin
        funct3_ok = 1'b1;
      end
      default:
      begin
        funct3_ok = 1'b0;
      end
    endcase
  end

  assign illegal = !(is_system && funct3_ok);

  always_comb
  begin
    if (illegal)
    begin
      op = CSR_NONE;
    end
    else
    begin
      op = csr_op_e'(funct3);
    end
  end

  // the top funct3 bit selects the immediate forms
  assign imm_form = funct3[2];

  always_comb
  begin
    if (imm_form)
    begin
      src_idx = inst.imm_fmt.uimm;
    end
    else
    begin
      src_idx = inst.reg_fmt.rs1;
    end
  end

  // csr and rd sit at the same place in both views
  assign csr_addr = inst.reg_fmt.csr;
  assign rd       = inst.reg_fmt.rd;

endmodule

/* csr_execute.sv */
// CSR instruction capture, counted access sequencer, retire and trap generation
`timescale 1ns/1ps
`include "zicsr_cfg.svh"

module csr_execute (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   inst_vld,
  input  logic [`ZICSR_XLEN-1:0] pc,
  input  logic [`ZICSR_XLEN-1:0] rs1_data,
  input  zicsr_pkg::csr_op_e     op,
  input  logic [11:0]            csr_addr_in,
  input  logic [4:0]             src_idx,
  input  logic [4:0]             rd_in,
  output logic                   busy,
  output logic                   retired,
  output logic                   trap,
  output zicsr_pkg::trap_cause_e trap_cause,
  output logic                   rd_wr,
  output logic [4:0]             rd,
  output logic [`ZICSR_XLEN-1:0] rd_data,
  output logic [`ZICSR_XLEN-1:0] pc_next,
  output logic                   csr_req,
  output logic                   csr_write,
  output logic [11:0]            csr_addr,
  output logic [`ZICSR_XLEN-1:0] csr_mask,
  output logic [`ZICSR_XLEN-1:0] csr_data_wr,
  input  logic                   csr_ack,
  input  logic [`ZICSR_XLEN-1:0] csr_data_rd,
  input  logic                   csr_err
);

  import zicsr_pkg::*;

  localparam logic [`ZICSR_XLEN-1:0] PC_STEP = 4;

  // captured instruction
  csr_op_e                op_q;
  logic [4:0]             src_q;
  logic [`ZICSR_XLEN-1:0] pc_q;
  logic [`ZICSR_XLEN-1:0] rs1_q;

  // 0 issue or early trap, 1 access in flight, 2 retire on the ack
  logic [1:0]             cnt;

  logic [`ZICSR_XLEN-1:0] src_val;
  logic [`ZICSR_XLEN-1:0] mask_nxt;
  logic [`ZICSR_XLEN-1:0] data_nxt;
  logic                   write_nxt;
  logic                   misaligned;
  logic                   capture;
  logic                   early_exit;
  logic                   final_step;

  assign capture    = !busy && inst_vld;
  assign misaligned = (pc_q[1:0] != 2'b00);
  assign early_exit = busy && (cnt == 2'd0) && ((op_q == CSR_NONE) || misaligned);
  assign final_step = busy && (cnt == 2'd2) && csr_ack;

  // immediate forms use the zero-extended uimm exactly where the register forms use rs1
  assign src_val = op_q[2] ? {{(`ZICSR_XLEN-5){1'b0}}, src_q} : rs1_q;

  always_comb
  begin
    case (op_q)
      CSR_RW,
      CSR_RWI:
      begin
        mask_nxt  = '1;
        data_nxt  = src_val;
        write_nxt = 1'b1;
      end
      CSR_RS,
      CSR_RSI:
      begin
        mask_nxt  = src_val;
        data_nxt  = '1;
        write_nxt = (src_q != 5'd0);
      end
      CSR_RC,
      CSR_RCI:
      begin
        mask_nxt  = src_val;
        data_nxt  = '0;
        write_nxt = (src_q != 5'd0);
      end
      default:
      begin
        mask_nxt  = '0;
        data_nxt  = '0;
        write_nxt = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy    <= 1'b0;
      retired <= 1'b0;
      trap    <= 1'b0;
      rd_wr   <= 1'b0;
      csr_req <= 1'b0;
      cnt     <= 2'd0;
    end
    else
    begin
      retired <= 1'b0;
      trap    <= 1'b0;
      rd_wr   <= 1'b0;
      csr_req <= 1'b0;
      if (capture)
      begin
        busy <= 1'b1;
        cnt  <= 2'd0;
      end
      else if (early_exit)
      begin
        busy    <= 1'b0;
        retired <= 1'b1;
        trap    <= 1'b1;
      end
      else if (final_step)
      begin
        busy    <= 1'b0;
        retired <= 1'b1;
        trap    <= csr_err;
        rd_wr   <= !csr_err;
        cnt     <= 2'd0;
      end
      else if (busy)
      begin
        csr_req <= (cnt == 2'd0);
        cnt     <= cnt + 2'd1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (capture)
    begin
      op_q     <= op;
      src_q    <= src_idx;
      rd       <= rd_in;
      csr_addr <= csr_addr_in;
      pc_q     <= pc;
      rs1_q    <= rs1_data;
    end
    if (busy && (cnt == 2'd0))
    begin
      csr_write   <= write_nxt;
      csr_mask    <= mask_nxt;
      csr_data_wr <= data_nxt;
    end
    // a trap leaves pc_next on the faulting instruction
    if (early_exit)
    begin
      trap_cause <= misaligned ? TRAP_MISALIGNED_PC : TRAP_ILLEGAL_INST;
      rd_data    <= '0;
      pc_next    <= pc_q;
    end
    else if (final_step)
    begin
      trap_cause <= csr_err ? TRAP_CSR_ACCESS : TRAP_NONE;
      rd_data    <= (csr_err || (rd == 5'd0)) ? '0 : csr_data_rd;
      pc_next    <= csr_err ? pc_q : pc_q + PC_STEP;
    end
  end

  // the CSR file has a fixed one cycle response
  a_ack_after_req : assert property (@(posedge clk) disable iff (rst) csr_req |=> csr_ack);

  a_retire_from_busy : assert property (@(posedge clk) disable iff (rst) retired |-> $past(busy));

  a_req_while_busy : assert property (@(posedge clk) disable iff (rst) csr_req |-> busy);

endmodule

/* csr_file.sv */
// machine mode CSR registers with masked read-modify-write and access error response
`timescale 1ns/1ps
`include "zicsr_cfg.svh"

module csr_file (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   csr_req,
  input  logic                   csr_write,
  input  logic [11:0]            csr_addr,
  input  logic [`ZICSR_XLEN-1:0] csr_mask,
  input  logic [`ZICSR_XLEN-1:0] csr_data_wr,
  output logic                   csr_ack,
  output logic [`ZICSR_XLEN-1:0] csr_data_rd,
  output logic                   csr_err
);

  localparam logic [`ZICSR_XLEN-1:0] MSTATUS_WMASK = `ZICSR_MSTATUS_WMASK;

  logic [`ZICSR_XLEN-1:0] mstatus;
  logic [`ZICSR_XLEN-1:0] mtvec;
  logic [`ZICSR_XLEN-1:0] mscratch;
  logic [`ZICSR_XLEN-1:0] mepc;
  logic [`ZICSR_XLEN-1:0] mcause;

  logic [`ZICSR_XLEN-1:0] old_val;
  logic [`ZICSR_XLEN-1:0] merged;
  logic                   hit;
  logic                   read_only;
  logic                   access_err;
  logic                   do_write;

  always_comb
  begin
    hit       = 1'b1;
    read_only = 1'b0;
    case (csr_addr)
      `ZICSR_ADDR_MSTATUS:  old_val = mstatus;
      `ZICSR_ADDR_MTVEC:    old_val = mtvec;
      `ZICSR_ADDR_MSCRATCH: old_val = mscratch;
      `ZICSR_ADDR_MEPC:     old_val = mepc;
      `ZICSR_ADDR_MCAUSE:   old_val = mcause;
      `ZICSR_ADDR_MHARTID:
      begin
        old_val   = `ZICSR_HARTID;
        read_only = 1'b1;
      end
      default:
      begin
        old_val = '0;
        hit     = 1'b0;
      end
    endcase
  end

  // masked bits take the new data, the rest keep the old value
  assign merged     = (old_val & ~csr_mask) | (csr_data_wr & csr_mask);
  assign access_err = !hit || (read_only && csr_write);
  assign do_write   = csr_req && csr_write && !access_err;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mstatus  <= '0;
      mtvec    <= '0;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
    end
    else if (do_write)
    begin
      case (csr_addr)
        `ZICSR_ADDR_MSTATUS:  mstatus  <= (mstatus & ~MSTATUS_WMASK) | (merged & MSTATUS_WMASK);
        `ZICSR_ADDR_MTVEC:    mtvec    <= merged;
        `ZICSR_ADDR_MSCRATCH: mscratch <= merged;
        // instructions are word aligned here, so the low two bits of mepc stay zero
        `ZICSR_ADDR_MEPC:     mepc     <= {merged[`ZICSR_XLEN-1:2], 2'b00};
        `ZICSR_ADDR_MCAUSE:   mcause   <= merged;
        default:
        begin
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      csr_ack <= 1'b0;
    end
    else
    begin
      csr_ack <= csr_req;
    end
  end

  // the read data is the value before any write of the same access
  always_ff @(posedge clk)
  begin
    if (csr_req)
    begin
      csr_data_rd <= old_val;
      csr_err     <= access_err;
    end
  end

  a_ack_has_req : assert property (@(posedge clk) disable iff (rst) csr_ack |-> $past(csr_req));

endmodule

/* csr_unit.sv */
// CSR unit top: decoder, execute sequencer and machine CSR file
`timescale 1ns/1ps

module csr_unit (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   inst_vld,
  input  zicsr_pkg::csr_inst_u   inst,
  input  logic [31:0]            pc,
  input  logic [31:0]            rs1_data,
  output logic                   busy,
  output logic                   retired,
  output logic                   trap,
  output zicsr_pkg::trap_cause_e trap_cause,
  output logic                   rd_wr,
  output logic [4:0]             rd,
  output logic [31:0]            rd_data,
  output logic [31:0]            pc_next
);

  import zicsr_pkg::*;

  csr_op_e     dec_op;
  logic [11:0] dec_csr_addr;
  logic [4:0]  dec_src_idx;
  logic [4:0]  dec_rd;

  logic        csr_req;
  logic        csr_write;
  logic [11:0] csr_addr;
  logic [31:0] csr_mask;
  logic [31:0] csr_data_wr;
  logic        csr_ack;
  logic [31:0] csr_data_rd;
  logic        csr_err;

  // an illegal word already shows up as CSR_NONE on op
  csr_decode i_csr_decode (
    .inst     (inst),
    .op       (dec_op),
    .csr_addr (dec_csr_addr),
    .src_idx  (dec_src_idx),
    .rd       (dec_rd),
    .illegal  ()
  );

  csr_execute i_csr_execute (
    .clk         (clk),
    .rst         (rst),
    .inst_vld    (inst_vld),
    .pc          (pc),
    .rs1_data    (rs1_data),
    .op          (dec_op),
    .csr_addr_in (dec_csr_addr),
    .src_idx     (dec_src_idx),
    .rd_in       (dec_rd),
    .busy        (busy),
    .retired     (retired),
    .trap        (trap),
    .trap_cause  (trap_cause),
    .rd_wr       (rd_wr),
    .rd          (rd),
    .rd_data     (rd_data),
    .pc_next     (pc_next),
    .csr_req     (csr_req),
    .csr_write   (csr_write),
    .csr_addr    (csr_addr),
    .csr_mask    (csr_mask),
    .csr_data_wr (csr_data_wr),
    .csr_ack     (csr_ack),
    .csr_data_rd (csr_data_rd),
    .csr_err     (csr_err)
  );

  csr_file i_csr_file (
    .clk         (clk),
    .rst         (rst),
    .csr_req     (csr_req),
    .csr_write   (csr_write),
    .csr_addr    (csr_addr),
    .csr_mask    (csr_mask),
    .csr_data_wr (csr_data_wr),
    .csr_ack     (csr_ack),
    .csr_data_rd (csr_data_rd),
    .csr_err     (csr_err)
  );

endmodule

/* tb_csr_unit.sv */
// CSR unit testbench with clock, reset, file driven instructions, compare tasks and timeouts
`timescale 1ns/1ps
`include "zicsr_cfg.svh"

module tb_csr_unit;

  import zicsr_pkg::*;

  localparam int FIELDS       = 8;
  localparam int MAX_VECTORS  = 64;
  localparam int IDLE_LIMIT   = 20;
  localparam int RETIRE_LIMIT = 20;
  localparam int LAT_EARLY    = 1;
  localparam int LAT_ACCESS   = 3;

  logic                   clk;
  logic                   rst;
  logic                   inst_vld;
  csr_inst_u              inst;
  logic [`ZICSR_XLEN-1:0] pc;
  logic [`ZICSR_XLEN-1:0] rs1_data;
  logic                   busy;
  logic                   retired;
  logic                   trap;
  trap_cause_e            trap_cause;
  logic                   rd_wr;
  logic [4:0]             rd;
  logic [`ZICSR_XLEN-1:0] rd_data;
  logic [`ZICSR_XLEN-1:0] pc_next;

  // eight words per instruction, in the column order of the stimulus file
  logic [`ZICSR_XLEN-1:0] stim_mem [0:FIELDS*MAX_VECTORS-1];
  int                     vec_cnt;
  int                     cur_vec;

  csr_unit i_csr_unit (
    .clk        (clk),
    .rst        (rst),
    .inst_vld   (inst_vld),
    .inst       (inst),
    .pc         (pc),
    .rs1_data   (rs1_data),
    .busy       (busy),
    .retired    (retired),
    .trap       (trap),
    .trap_cause (trap_cause),
    .rd_wr      (rd_wr),
    .rd         (rd),
    .rd_data    (rd_data),
    .pc_next    (pc_next)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run();
    $display("Regression failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_data(input string name, input logic [`ZICSR_XLEN-1:0] got,
                            input logic [`ZICSR_XLEN-1:0] exp);
    if (got !== exp)
    begin
      $display("FAILED at %0d ns: vector %0d %s got %h, expected %h",
               $time, cur_vec, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_cause(input string name, input trap_cause_e got, input trap_cause_e exp);
    if (got !== exp)
    begin
      $display("FAILED at %0d ns: vector %0d %s got %0d, expected %0d",
               $time, cur_vec, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("FAILED at %0d ns: vector %0d %s got %b, expected %b",
               $time, cur_vec, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_index(input string name, input logic [4:0] got, input logic [4:0] exp);
    if (got !== exp)
    begin
      $display("FAILED at %0d ns: vector %0d %s got %0d, expected %0d",
               $time, cur_vec, name, got, exp);
      abort_run();
    end
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (busy)
    begin
      if (cycles == IDLE_LIMIT)
      begin
        $display("timeout at %0d ns: busy stayed high for %0d cycles", $time, cycles);
        abort_run();
      end
      @(posedge clk);
      #1;
      cycles++;
    end
  endtask

  // counts cycles from the capture edge until retired is seen
  task automatic wait_retire(output int cycles);
    cycles = 0;
    while (!retired)
    begin
      if (cycles == RETIRE_LIMIT)
      begin
        $display("timeout at %0d ns: vector %0d never retired", $time, cur_vec);
        abort_run();
      end
      @(posedge clk);
      #1;
      cycles++;
    end
  endtask

  task automatic run_vector(input int idx);
    int                     base;
    int                     lat;
    int                     exp_lat;
    logic                   exp_trap;
    trap_cause_e            exp_cause;
    logic                   exp_rd_wr;
    logic [4:0]             exp_rd;
    logic [`ZICSR_XLEN-1:0] exp_rd_data;
    logic [`ZICSR_XLEN-1:0] exp_pc_next;
    base    = idx * FIELDS;
    cur_vec = idx;
    wait_idle();
    inst     = stim_mem[base];
    pc       = stim_mem[base+1];
    rs1_data = stim_mem[base+2];
    inst_vld = 1'b1;
    @(posedge clk);
    #1;
    inst_vld = 1'b0;
    wait_retire(lat);
    exp_trap    = stim_mem[base+3][0];
    exp_cause   = trap_cause_e'(stim_mem[base+4][3:0]);
    exp_rd_wr   = stim_mem[base+5][0];
    exp_rd_data = stim_mem[base+6];
    exp_pc_next = stim_mem[base+7];
    // the write-back goes to the destination field of the instruction word
    exp_rd      = stim_mem[base][11:7];
    // a bad opcode or pc traps before any CSR access, everything else takes the full sequence
    if (exp_trap && (exp_cause != TRAP_CSR_ACCESS))
    begin
      exp_lat = LAT_EARLY;
    end
    else
    begin
      exp_lat = LAT_ACCESS;
    end
    check_flag("trap", trap, exp_trap);
    check_cause("trap_cause", trap_cause, exp_cause);
    check_flag("rd_wr", rd_wr, exp_rd_wr);
    if (exp_rd_wr)
    begin
      check_index("rd", rd, exp_rd);
    end
    check_data("rd_data", rd_data, exp_rd_data);
    check_data("pc_next", pc_next, exp_pc_next);
    check_flag("busy", busy, 1'b0);
    check_data("retire latency", lat, exp_lat);
  endtask

  initial
  begin
    rst      = 1'b1;
    inst_vld = 1'b0;
    inst     = '0;
    pc       = '0;
    rs1_data = '0;
    cur_vec  = -1;
    vec_cnt  = 0;
    // words not given by the file keep an address based pattern that no instruction matches
    for (int k = 0; k < FIELDS*MAX_VECTORS; k++)
    begin
      stim_mem[k] = ~k;
    end
    $readmemh("csr_stim.txt", stim_mem);
    while ((vec_cnt < MAX_VECTORS) && (stim_mem[vec_cnt*FIELDS] !== ~(vec_cnt*FIELDS)))
    begin
      vec_cnt++;
    end
    if (vec_cnt == 0)
    begin
      $display("no instructions could be read from csr_stim.txt");
      abort_run();
    end
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    check_flag("busy", busy, 1'b0);
    check_flag("retired", retired, 1'b0);
    check_flag("trap", trap, 1'b0);
    check_flag("rd_wr", rd_wr, 1'b0);
    for (int i = 0; i < vec_cnt; i++)
    begin
      run_vector(i);
    end
    wait_idle();
    $display("Regression passed");
    $finish;
  end

endmodule

/* csr_stim.txt */
// inst pc rs1_data | expected: trap trap_cause rd_wr rd_data pc_next
// trap_cause: 0 misaligned pc, 2 illegal instruction, e clean retire, f bad CSR access
// csrrw mscratch, then two reads with rs1 index 0
340312f3 00001000 deadbeef 0 e 1 00000000 00001004
340023f3 00001004 ffffffff 0 e 1 deadbeef 00001008
340023f3 00001008 ffffffff 0 e 1 deadbeef 0000100c
// mtvec: write, register set and clear, immediate set and clear, final read
305110f3 0000100c 0000f0f0 0 e 1 00000000 00001010
3051a0f3 00001010 0f00000f 0 e 1 0000f0f0 00001014
305230f3 00001014 000000f0 0 e 1 0f00f0ff 00001018
305ae0f3 00001018 ffffffff 0 e 1 0f00f00f 0000101c
305670f3 0000101c ffffffff 0 e 1 0f00f01f 00001020
305020f3 00001020 00000000 0 e 1 0f00f013 00001024
// mstatus keeps MIE and MPIE only, mepc drops bits 1:0
30049473 00001024 ffffffff 0 e 1 00000000 00001028
30002473 00001028 00000000 0 e 1 00000088 0000102c
34149473 0000102c 80001237 0 e 1 00000000 00001030
34102473 00001030 00000000 0 e 1 80001234 00001034
// rd of 0 still writes back, with zero data
34031073 00001034 12345678 0 e 1 00000000 00001038
340023f3 00001038 00000000 0 e 1 12345678 0000103c
// addi and ecall are not CSR instructions
00500093 0000103c 00000000 1 2 0 00000000 0000103c
00000073 00001040 00000000 1 2 0 00000000 00001040
// misaligned pc on a csrrw to mscratch
340312f3 00001046 aaaaaaaa 1 0 0 00000000 00001046
// mscratch and mtvec are untouched by the traps
340023f3 00001048 00000000 0 e 1 12345678 0000104c
305020f3 0000104c 00000000 0 e 1 0f00f013 00001050
// unknown address, write to mhartid, then plain reads of mhartid
7c0023f3 00001050 00000000 1 f 0 00000000 00001050
f14313f3 00001054 00000055 1 f 0 00000000 00001054
f14023f3 00001058 00000000 0 e 1 00000001 0000105c
f14063f3 0000105c 00000000 0 e 1 00000001 00001060

/* build.f */
+incdir+.
zicsr_pkg.sv
csr_decode.sv
csr_execute.sv
csr_file.sv
csr_unit.sv
tb_csr_unit.sv

/* Bender.yml */
package:
  name: zicsr_csr_unit

sources:
  - include_dirs:
      - .
    files:
      - zicsr_pkg.sv
      - csr_decode.sv
      - csr_execute.sv
      - csr_file.sv
      - csr_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_csr_unit.sv
